//--- synth_macros.svh
// Synth constants: voice count, sample and phase sizes, scan codes and control limits
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// ==============================
// Sizes
// ==============================
`define MAX_KEYS        8       // Voices, one per held note
`define PWM_BITS        10      // Sample width and PWM resolution
`define PHASE_WIDTH     32      // Accumulator width
`define LUT_ADDR_BITS   5       // Sine table has 32 entries
`define DELAY_DEPTH     1024    // Echo length in samples
`define PHASE_INC_MULT  42      // Hz to phase step

// ==============================
// Scan codes (make codes, set 2)
// ==============================
`define KEY_Z           8'h1A   // Octave down
`define KEY_X           8'h22   // Octave up
`define KEY_C           8'h21   // Echo toggle
`define KEY_V           8'h2A   // Pitch offset down
`define KEY_B           8'h32   // Pitch offset up
`define BREAK_PREFIX    8'hF0   // Next byte is a release

// Control limits
`define MAX_OCTAVE      3       // Octave shift saturates at +/- this
`define MAX_PITCH_MOD   100     // Pitch offset limit in Hz
`define PITCH_MOD_STEP  4       // Hz per V/B press

`endif

//--- synth_pkg.sv
// Synth shared types and the scan-code to note frequency lookup
`include "synth_macros.svh"

package synth_pkg;

    typedef logic [7:0]                   key_code_t;   // PS/2 scan byte
    typedef logic [11:0]                  tone_freq_t;  // Note frequency in Hz
    typedef logic signed [2:0]            octave_t;     // -3 .. +3
    typedef logic signed [7:0]            pitch_mod_t;  // -100 .. +100 Hz
    typedef logic [`PHASE_WIDTH-1:0]      phase_t;      // DDS accumulator
    typedef logic [`PWM_BITS-1:0]         sample_t;     // Audio sample
    typedef logic [`PWM_BITS+4:0]         mix_sum_t;    // Room for eight voices

    // ==============================
    // One octave of keys, C4 to C5
    // ==============================
    // Home row are white keys, top row the black ones in between
    function automatic tone_freq_t key_to_freq(input key_code_t code);
        case (code)
            8'h1C:   return 12'd262;    // A  C4
            8'h1D:   return 12'd277;    // W  C#4
            8'h1B:   return 12'd294;    // S  D4
            8'h24:   return 12'd311;    // E  D#4
            8'h23:   return 12'd330;    // D  E4
            8'h2B:   return 12'd349;    // F  F4
            8'h2C:   return 12'd370;    // T  F#4
            8'h34:   return 12'd392;    // G  G4
            8'h35:   return 12'd415;    // Y  G#4
            8'h33:   return 12'd440;    // H  A4
            8'h3C:   return 12'd466;    // U  A#4
            8'h3B:   return 12'd494;    // J  B4
            8'h42:   return 12'd523;    // K  C5
            default: return 12'd0;      // Not a note key
        endcase
    endfunction

endpackage

//--- key_event_decoder.sv
// Key event decoder: turns make/break scan bytes into voice slots and control state
`timescale 1ns/100ps
`include "synth_macros.svh"

module key_event_decoder import synth_pkg::*; (
    input  logic                 modclk,
    input  logic                 reset,
    input  key_code_t            key_code,
    input  logic                 key_strobe,                 // One cycle per byte
    output logic [`MAX_KEYS-1:0] voice_active,
    output tone_freq_t           voice_freq [`MAX_KEYS],
    output octave_t              octave_shift,
    output pitch_mod_t           pitch_mod,
    output logic                 delay_on
);

    localparam int         SLOT_BITS   = $clog2(`MAX_KEYS);
    localparam octave_t    OCT_LIMIT   = octave_t'(`MAX_OCTAVE);
    localparam octave_t    OCT_STEP    = octave_t'(1);
    localparam pitch_mod_t PITCH_LIMIT = pitch_mod_t'(`MAX_PITCH_MOD);
    localparam pitch_mod_t PITCH_STEP  = pitch_mod_t'(`PITCH_MOD_STEP);

    logic                 break_armed;                       // F0 seen, next byte releases
    key_code_t            slot_code [`MAX_KEYS];             // Code held by each slot
    logic [SLOT_BITS-1:0] free_idx;
    logic                 free_found;
    logic                 is_break;
    logic                 make_ev;
    tone_freq_t           note_freq;
    logic                 note_on;

    // ==============================
    // Byte classification
    // ==============================
    assign is_break  = (key_code == `BREAK_PREFIX);
    assign make_ev   = key_strobe && !is_break && !break_armed;
    assign note_freq = key_to_freq(key_code);                // Zero for control keys too
    assign note_on   = make_ev && (note_freq != '0) && free_found;

    // Lowest free slot; descending scan so the smallest index wins
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = `MAX_KEYS - 1; i >= 0; i--) begin
            if (!voice_active[i]) begin
                free_idx   = SLOT_BITS'(i);
                free_found = 1'b1;
            end
        end
    end

    // ==============================
    // Control state and slot flags
    // ==============================
    always_ff @(posedge modclk or posedge reset) begin
        if (reset) begin
            break_armed  <= 1'b0;
            octave_shift <= '0;
            pitch_mod    <= '0;
            delay_on     <= 1'b0;
            voice_active <= '0;
        end else if (key_strobe) begin
            if (is_break) begin
                break_armed <= 1'b1;
            end else if (break_armed) begin
                break_armed <= 1'b0;
                // Release every slot holding this key, duplicates included
                for (int i = 0; i < `MAX_KEYS; i++) begin
                    if (voice_active[i] && (slot_code[i] == key_code))
                        voice_active[i] <= 1'b0;
                end
            end else begin
                case (key_code)
                    `KEY_Z: if (octave_shift > -OCT_LIMIT) octave_shift <= octave_shift - OCT_STEP;
                    `KEY_X: if (octave_shift < OCT_LIMIT) octave_shift <= octave_shift + OCT_STEP;
                    `KEY_C: delay_on <= ~delay_on;
                    `KEY_V: if (pitch_mod > -PITCH_LIMIT) pitch_mod <= pitch_mod - PITCH_STEP;
                    `KEY_B: if (pitch_mod < PITCH_LIMIT) pitch_mod <= pitch_mod + PITCH_STEP;
                    default: begin
                        if (note_on)
                            voice_active[free_idx] <= 1'b1;  // No free slot: key dropped
                    end
                endcase
            end
        end
    end

    // Slot payload, only meaningful while the slot flag is set
    always_ff @(posedge modclk) begin
        if (note_on) begin
            slot_code[free_idx]  <= key_code;
            voice_freq[free_idx] <= note_freq;
        end
    end

    // Saturation must hold over any key sequence
    a_octave_range: assert property (@(posedge modclk) disable iff (reset)
        (octave_shift >= -OCT_LIMIT) && (octave_shift <= OCT_LIMIT));
    a_pitch_range: assert property (@(posedge modclk) disable iff (reset)
        (pitch_mod >= -PITCH_LIMIT) && (pitch_mod <= PITCH_LIMIT));

endmodule

//--- voice_bank.sv
// Voice bank: per-voice frequency with octave and pitch offset, and its phase accumulator
`timescale 1ns/100ps
`include "synth_macros.svh"

module voice_bank import synth_pkg::*; (
    input  logic                 modclk,
    input  logic                 reset,
    input  logic [`MAX_KEYS-1:0] voice_active,
    input  tone_freq_t           voice_freq [`MAX_KEYS],
    input  octave_t              octave_shift,
    input  pitch_mod_t           pitch_mod,
    output phase_t               phase [`MAX_KEYS],
    output logic [`MAX_KEYS-1:0] voice_active_q       // Aligned with phase
);

    localparam int FREQ_W = $bits(tone_freq_t) + `MAX_OCTAVE;  // Base after <<3

    logic [1:0] shift_amt;                                     // Magnitude of the octave shift

    assign shift_amt = octave_shift[2] ? 2'(-octave_shift) : octave_shift[1:0];

    for (genvar k = 0; k < `MAX_KEYS; k++) begin : g_voice
        logic [FREQ_W-1:0]        base_ext;
        logic [FREQ_W-1:0]        shifted;
        logic signed [FREQ_W+1:0] freq_sum;                    // Signed, offset may go negative
        logic [FREQ_W:0]          freq_clamped;
        phase_t                   phase_inc;

        assign base_ext     = {3'b000, voice_freq[k]};
        assign shifted      = octave_shift[2] ? (base_ext >> shift_amt) : (base_ext << shift_amt);
        assign freq_sum     = $signed({2'b00, shifted}) + pitch_mod;
        assign freq_clamped = freq_sum[FREQ_W+1] ? '0 : freq_sum[FREQ_W:0];  // Floor at 0 Hz
        assign phase_inc    = phase_t'(freq_clamped) * phase_t'(`PHASE_INC_MULT);  // Wraps

        always_ff @(posedge modclk or posedge reset) begin
            if (reset)
                phase[k] <= '0;
            else if (voice_active[k])
                phase[k] <= phase[k] + phase_inc;
        end

        // Released voice freezes where it stopped
        a_idle_hold: assert property (@(posedge modclk) disable iff (reset)
            !voice_active[k] |=> $stable(phase[k]));
    end

    // Active flags delayed to match the registered phase
    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            voice_active_q <= '0;
        else
            voice_active_q <= voice_active;
    end

endmodule

//--- voice_mixer.sv
// Voice mixer: sine lookup per active voice, sum of all voices, scaled and registered
`timescale 1ns/100ps
`include "synth_macros.svh"

module voice_mixer import synth_pkg::*; (
    input  logic                 modclk,
    input  logic                 reset,
    input  phase_t               phase [`MAX_KEYS],
    input  logic [`MAX_KEYS-1:0] voice_active_q,
    output sample_t              mixed_sample
);

    sample_t  sine_lut [1 << `LUT_ADDR_BITS];             // One full period, unsigned
    mix_sum_t mix_sum;

    initial $readmemh("sine_lut.mem", sine_lut);

    // ==============================
    // Sum of active voices
    // ==============================
    always_comb begin
        mix_sum = '0;
        for (int k = 0; k < `MAX_KEYS; k++) begin
            if (voice_active_q[k])
                mix_sum = mix_sum +
                    mix_sum_t'(sine_lut[phase[k][`PHASE_WIDTH-1 -: `LUT_ADDR_BITS]]);  // Top bits
        end
    end

    // Divide by four; more than four loud voices wrap
    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            mixed_sample <= '0;
        else
            mixed_sample <= sample_t'(mix_sum >> 2);
    end

endmodule

//--- audio_output.sv
// Audio output: echo delay line, dry/echo select, and PWM modulation of the sample
`timescale 1ns/100ps
`include "synth_macros.svh"

module audio_output import synth_pkg::*; (
    input  logic    modclk,
    input  logic    reset,
    input  sample_t mixed_sample,
    input  logic    delay_on,
    output logic    audio_pwm
);

    localparam int PTR_BITS = $clog2(`DELAY_DEPTH);

    sample_t               delay_buf [`DELAY_DEPTH];      // Circular echo history
    logic [PTR_BITS-1:0]   delay_ptr;
    sample_t               delayed_sample;
    logic [`PWM_BITS:0]    echo_sum;                      // One extra bit for the carry
    sample_t               out_sample;
    logic [`PWM_BITS-1:0]  pwm_count;

    // ==============================
    // Echo
    // ==============================
    assign delayed_sample = delay_buf[delay_ptr];        // Old value, read before the write
    assign echo_sum       = {1'b0, mixed_sample} + {1'b0, delayed_sample};
    assign out_sample     = delay_on ? echo_sum[`PWM_BITS:1] : mixed_sample;  // 50/50 mix

    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            delay_ptr <= '0;
        else
            delay_ptr <= delay_ptr + 1'b1;               // Wraps at DELAY_DEPTH
    end

    always_ff @(posedge modclk) begin
        delay_buf[delay_ptr] <= mixed_sample;
    end

    // ==============================
    // PWM
    // ==============================
    always_ff @(posedge modclk or posedge reset) begin
        if (reset) begin
            pwm_count <= '0;
            audio_pwm <= 1'b0;
        end else begin
            pwm_count <= pwm_count + 1'b1;               // Free running
            audio_pwm <= (pwm_count < out_sample);       // Duty cycle = sample / 1024
        end
    end

    a_pwm_step: assert property (@(posedge modclk) disable iff (reset)
        1'b1 |=> (pwm_count == $past(pwm_count) + 10'd1));

endmodule

//--- synth_top.sv
// Synth top: scan-code decoder, voice bank, mixer and PWM output chained together
`timescale 1ns/100ps
`include "synth_macros.svh"

module synth_top import synth_pkg::*; (
    input  logic                 modclk,
    input  logic                 reset,
    input  key_code_t            key_code,
    input  logic                 key_strobe,
    output logic                 audio_pwm,
    output logic [`MAX_KEYS-1:0] voice_leds          // One LED per busy slot
);

    tone_freq_t           voice_freq [`MAX_KEYS];
    octave_t              octave_shift;
    pitch_mod_t           pitch_mod;
    logic                 delay_on;
    phase_t               phase [`MAX_KEYS];
    logic [`MAX_KEYS-1:0] voice_active_q;
    sample_t              mixed_sample;

    // ==============================
    // Input side
    // ==============================
    key_event_decoder u_key_event_decoder (
        .modclk       (modclk),
        .reset        (reset),
        .key_code     (key_code),
        .key_strobe   (key_strobe),
        .voice_active (voice_leds),                  // Slot flags double as LEDs
        .voice_freq   (voice_freq),
        .octave_shift (octave_shift),
        .pitch_mod    (pitch_mod),
        .delay_on     (delay_on)
    );

    // Processing
    voice_bank u_voice_bank (
        .modclk         (modclk),
        .reset          (reset),
        .voice_active   (voice_leds),
        .voice_freq     (voice_freq),
        .octave_shift   (octave_shift),
        .pitch_mod      (pitch_mod),
        .phase          (phase),
        .voice_active_q (voice_active_q)
    );

    voice_mixer u_voice_mixer (
        .modclk         (modclk),
        .reset          (reset),
        .phase          (phase),
        .voice_active_q (voice_active_q),
        .mixed_sample   (mixed_sample)               // One cycle after phase
    );

    // ==============================
    // Output side
    // ==============================
    audio_output u_audio_output (
        .modclk       (modclk),
        .reset        (reset),
        .mixed_sample (mixed_sample),
        .delay_on     (delay_on),
        .audio_pwm    (audio_pwm)                    // Two cycles after phase
    );

endmodule

//--- tb_synth_model.sv
// Synth reference model: key bytes to voice flags and PWM bit, one step per clock edge
`timescale 1ns/100ps
`include "synth_macros.svh"

module tb_synth_model import synth_pkg::*; (
    input  logic                 modclk,
    input  logic                 reset,
    input  key_code_t            key_code,
    input  logic                 key_strobe,
    output logic                 model_pwm,
    output logic [`MAX_KEYS-1:0] model_leds       // Busy slots
);

    localparam int SLOT_BITS = $clog2(`MAX_KEYS);
    localparam int PTR_BITS  = $clog2(`DELAY_DEPTH);

    logic                 brk;                    // Break prefix pending
    logic                 dly;                    // Echo enabled
    int                   oct;                    // Octave shift
    int                   pmod;                   // Pitch offset in Hz
    key_code_t            slot_code [`MAX_KEYS];
    int                   slot_freq [`MAX_KEYS];
    phase_t               ph [`MAX_KEYS];
    logic [`MAX_KEYS-1:0] act_q;                  // Flags one cycle late
    sample_t              mixed;
    sample_t              lut [1 << `LUT_ADDR_BITS];
    sample_t              hist [`DELAY_DEPTH];    // Echo history
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [`PWM_BITS-1:0] cnt;

    initial $readmemh("sine_lut.mem", lut);

    // Octave, signed offset, floor at 0 Hz, then Hz to phase step
    function automatic phase_t phase_step(input int base, input int octave, input int offset);
        int f;
        f = base;
        if (octave > 0)
            f = f << octave;
        else
            f = f >> (-octave);
        f = f + offset;
        if (f < 0)
            f = 0;
        return phase_t'(f * `PHASE_INC_MULT);
    endfunction

    always @(posedge modclk or posedge reset) begin : step
        int                   sum;
        int                   out;
        int                   f;
        logic [SLOT_BITS-1:0] slot;
        logic                 found;
        if (reset) begin
            brk        <= 1'b0;
            dly        <= 1'b0;
            oct        <= 0;
            pmod       <= 0;
            model_leds <= '0;
            act_q      <= '0;
            mixed      <= '0;
            wr_ptr     <= '0;
            cnt        <= '0;
            model_pwm  <= 1'b0;
            for (int k = 0; k < `MAX_KEYS; k++)
                ph[k] <= '0;
        end else begin
            // ==============================
            // Oscillators and mix
            // ==============================
            sum = 0;
            for (int k = 0; k < `MAX_KEYS; k++) begin
                if (model_leds[k])
                    ph[k] <= ph[k] + phase_step(slot_freq[k], oct, pmod);
                if (act_q[k])
                    sum = sum + int'(lut[ph[k][`PHASE_WIDTH-1 -: `LUT_ADDR_BITS]]);
            end
            act_q <= model_leds;
            mixed <= sample_t'(sum >> 2);         // Keeps only the low bits

            // Echo average and PWM compare
            out = int'(mixed);
            if (dly)
                out = (out + int'(hist[wr_ptr])) >> 1;
            model_pwm    <= (int'(cnt) < out);
            cnt          <= cnt + `PWM_BITS'(1);
            hist[wr_ptr] <= mixed;
            wr_ptr       <= wr_ptr + PTR_BITS'(1);

            // ==============================
            // Key bytes
            // ==============================
            if (key_strobe) begin
                if (key_code == `BREAK_PREFIX) begin
                    brk <= 1'b1;
                end else if (brk) begin
                    brk <= 1'b0;
                    for (int k = 0; k < `MAX_KEYS; k++)
                        if (model_leds[k] && slot_code[k] == key_code)
                            model_leds[k] <= 1'b0;    // All copies of the key
                end else begin
                    f = int'(key_to_freq(key_code));
                    case (key_code)
                        `KEY_Z: if (oct > -`MAX_OCTAVE) oct <= oct - 1;
                        `KEY_X: if (oct < `MAX_OCTAVE) oct <= oct + 1;
                        `KEY_C: dly <= ~dly;
                        `KEY_V: if (pmod > -`MAX_PITCH_MOD) pmod <= pmod - `PITCH_MOD_STEP;
                        `KEY_B: if (pmod < `MAX_PITCH_MOD) pmod <= pmod + `PITCH_MOD_STEP;
                        default: begin
                            found = 1'b0;
                            slot  = '0;
                            for (int k = 0; k < `MAX_KEYS; k++) begin
                                if (!found && !model_leds[k]) begin
                                    slot  = SLOT_BITS'(k);  // Lowest free wins
                                    found = 1'b1;
                                end
                            end
                            if (found && f != 0) begin
                                model_leds[slot] <= 1'b1;
                                slot_code[slot]  <= key_code;
                                slot_freq[slot]  <= f;
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

//--- tb_synth.sv
// Synth testbench with a key byte table, LED checks and a cycle-by-cycle audio compare to the model
`timescale 1ns/100ps
`include "synth_macros.svh"

module tb_synth import synth_pkg::*; ();

    localparam int IDLE_CYCLES = 1100;            // Quiet stretch after reset
    localparam int MAX_GAP     = 8;               // Longest idle gap between bytes
    localparam int NUM_ROWS    = 42;

    typedef struct packed {
        logic [2:0]  test_id;
        logic [7:0]  code;                        // Scan byte
        logic [7:0]  reps;                        // Times the byte is sent
        logic [15:0] wait_cycles;                 // Settle time before the LED check
        logic [7:0]  leds;                        // Expected voice_leds
    } stim_row_t;

    logic                 modclk = 1'b0;
    logic                 reset;
    key_code_t            key_code;
    logic                 key_strobe;
    logic                 audio_pwm;
    logic [`MAX_KEYS-1:0] voice_leds;
    logic                 model_pwm;
    logic [`MAX_KEYS-1:0] model_leds;
    string                test_name;
    int                   cycle_count = 0;
    int                   timeout_limit = 0;

    // ==============================
    // Stimulus table
    // ==============================
    stim_row_t stim_table [NUM_ROWS] = '{
        '{3'd1, 8'h1C, 8'd1, 16'd30, 8'h01},      // A into slot 0
        '{3'd1, 8'hF0, 8'd1, 16'd2, 8'h01},
        '{3'd1, 8'h1C, 8'd1, 16'd30, 8'h00},      // A released
        '{3'd1, 8'h33, 8'd1, 16'd30, 8'h01},
        '{3'd1, 8'h24, 8'd1, 16'd30, 8'h03},
        '{3'd1, 8'hF0, 8'd1, 16'd2, 8'h03},
        '{3'd1, 8'h33, 8'd1, 16'd30, 8'h02},      // Hole at slot 0
        '{3'd1, 8'h23, 8'd1, 16'd30, 8'h03},      // D fills the hole
        '{3'd1, 8'h24, 8'd1, 16'd30, 8'h07},      // E held twice
        '{3'd1, 8'hF0, 8'd1, 16'd2, 8'h07},
        '{3'd1, 8'h24, 8'd1, 16'd30, 8'h01},      // Both E slots freed
        '{3'd1, 8'hF0, 8'd1, 16'd2, 8'h01},
        '{3'd1, 8'h23, 8'd1, 16'd30, 8'h00},
        '{3'd2, 8'h1C, 8'd1, 16'd20, 8'h01},
        '{3'd2, 8'h1D, 8'd1, 16'd20, 8'h03},
        '{3'd2, 8'h1B, 8'd1, 16'd20, 8'h07},
        '{3'd2, 8'h24, 8'd1, 16'd20, 8'h0F},
        '{3'd2, 8'h23, 8'd1, 16'd20, 8'h1F},
        '{3'd2, 8'h2B, 8'd1, 16'd20, 8'h3F},
        '{3'd2, 8'h2C, 8'd1, 16'd20, 8'h7F},
        '{3'd2, 8'h34, 8'd1, 16'd300, 8'hFF},     // Eight voices wrap the sum
        '{3'd2, 8'h35, 8'd1, 16'd300, 8'hFF},     // Ninth key dropped
        '{3'd2, 8'hF0, 8'd1, 16'd2, 8'hFF},
        '{3'd2, 8'h24, 8'd1, 16'd100, 8'hF7},
        '{3'd2, 8'h35, 8'd1, 16'd100, 8'hFF},     // Y gets slot 3 now
        '{3'd2, 8'hF0, 8'd1, 16'd2, 8'hFF},
        '{3'd2, 8'h1C, 8'd1, 16'd20, 8'hFE},
        '{3'd2, 8'hF0, 8'd1, 16'd2, 8'hFE},
        '{3'd2, 8'h1D, 8'd1, 16'd20, 8'hFC},
        '{3'd2, 8'hF0, 8'd1, 16'd2, 8'hFC},
        '{3'd2, 8'h1B, 8'd1, 16'd100, 8'hF8},     // Five voices left
        '{3'd3, 8'h1A, 8'd4, 16'd300, 8'hF8},     // Z past -3
        '{3'd3, 8'h22, 8'd7, 16'd800, 8'hF8},     // X past +3
        '{3'd3, 8'h32, 8'd26, 16'd400, 8'hF8},    // B past +100
        '{3'd3, 8'h2A, 8'd51, 16'd400, 8'hF8},    // V past -100
        '{3'd3, 8'h32, 8'd25, 16'd200, 8'hF8},
        '{3'd3, 8'h1A, 8'd3, 16'd200, 8'hF8},
        '{3'd4, 8'h21, 8'd1, 16'd400, 8'hF8},     // Echo on
        '{3'd4, 8'h1C, 8'd1, 16'd1100, 8'hF9},    // A averaged with older samples for a PWM period
        '{3'd4, 8'h21, 8'd1, 16'd300, 8'hF9},     // Back to dry
        '{3'd4, 8'hF0, 8'd1, 16'd2, 8'hF9},
        '{3'd4, 8'h1C, 8'd1, 16'd1100, 8'hF8}     // Release heard dry for a PWM period
    };

    synth_top u_synth_top (
        .modclk     (modclk),
        .reset      (reset),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .audio_pwm  (audio_pwm),
        .voice_leds (voice_leds)
    );

    tb_synth_model u_synth_model (
        .modclk     (modclk),
        .reset      (reset),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .model_pwm  (model_pwm),
        .model_leds (model_leds)
    );

    always #5 modclk = ~modclk;                   // 10 ns period

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected %0h, actual %0h", test, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1:    return "note_on_off";
            3'd2:    return "polyphony";
            3'd3:    return "octave_pitch";
            3'd4:    return "echo";
            default: return "idle";
        endcase
    endfunction

    // Reset, idle, every byte with its longest gap, every wait, plus margin
    function automatic int cycle_budget();
        int total;
        int i;
        total = 10 + IDLE_CYCLES + 2000;
        for (i = 0; i < NUM_ROWS; i++)
            total = total + int'(stim_table[i].wait_cycles)
                    + int'(stim_table[i].reps) * (MAX_GAP + 2);
        return total;
    endfunction

    task automatic apply_row(input stim_row_t row);
        int gap;
        int r;
        test_name = test_label(row.test_id);
        for (r = 0; r < int'(row.reps); r++) begin
            @(negedge modclk);
            key_code   = row.code;
            key_strobe = 1'b1;
            @(negedge modclk);
            key_strobe = 1'b0;                    // One cycle per byte
            gap = int'($urandom_range(MAX_GAP, 1));
            repeat (gap) @(negedge modclk);
        end
        repeat (int'(row.wait_cycles)) @(negedge modclk);
        check_value(test_name, "voice_leds", 32'(row.leds), 32'(voice_leds));
    endtask

    // ==============================
    // Lockstep compare and timeout
    // ==============================
    always @(posedge modclk) begin
        #1;                                       // Let the edge settle
        check_value(test_name, "audio_pwm vs model", 32'(model_pwm), 32'(audio_pwm));
        check_value(test_name, "voice_leds vs model", 32'(model_leds), 32'(voice_leds));
    end

    always @(posedge modclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run did not end within %0d cycles", timeout_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int i;
        void'($urandom(67));
        reset         = 1'b1;
        key_code      = '0;
        key_strobe    = 1'b0;
        test_name     = "idle";
        timeout_limit = cycle_budget();
        repeat (10) @(negedge modclk);
        reset = 1'b0;
        // Silent output with no key pressed
        repeat (IDLE_CYCLES) begin
            @(negedge modclk);
            check_value(test_name, "voice_leds", 32'd0, 32'(voice_leds));
            check_value(test_name, "audio_pwm", 32'd0, 32'(audio_pwm));
        end
        for (i = 0; i < NUM_ROWS; i++)
            apply_row(stim_table[i]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sine_lut.mem
// One sine period, 32 unsigned 10-bit samples, one hex value per line
200
264
2C4
31C
369
3A9
3D8
3F5
3FF
3F5
3D8
3A9
369
31C
2C4
264
200
19C
13C
0E4
097
057
028
00B
001
00B
028
057
097
0E4
13C
19C

//--- vlog.f
+incdir+.
synth_pkg.sv
key_event_decoder.sv
voice_bank.sv
voice_mixer.sv
audio_output.sv
synth_top.sv
tb_synth_model.sv
tb_synth.sv

//--- Makefile
# Verilator build and run of the synth testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_synth
FILELIST := vlog.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
